// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_mixer
RTL_TOP    := mixer_top
FLIST      := mixer.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// File: include/mixer_defs.svh
`ifndef MIXER_DEFS_SVH
`define MIXER_DEFS_SVH

// audio path
`define MIX_AUDIO_WIDTH      24
`define MIX_NR_OF_CHANNELS   4
`define MIX_Q_BITS           16      // unity gain = 65536
`define MIX_CLIP_HOLD_CYCLES 1024    // led on-time after a clip

// wishbone register port, word addresses
`define MIX_WB_ADDR_WIDTH    4
`define MIX_REG_CMD          0       // bit 0 clears min/max, clip, overrun
`define MIX_REG_GAIN0        1       // gains at 1..4
`define MIX_REG_PAN0         5       // pans at 5..8
`define MIX_REG_OUT_GAIN     9
`define MIX_REG_STATUS       10
`define MIX_REG_MAX          11
`define MIX_REG_MIN          12

`endif

// File: logic/dac_egress.sv
`timescale 1ns/100ps
`include "mixer_defs.svh"

module dac_egress import mixer_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         mix_valid,
  input  stereo_t      mix_out,
  input  logic         dac_ready,
  input  logic         clear,
  input  clip_status_t status,
  output sample_t      dac_data,
  output logic         dac_valid,
  output logic         dac_last,
  output sample_t      dac_max,
  output sample_t      dac_min,
  output logic         overrun,
  output logic         clip_led
);

  localparam int      HOLD_W     = $clog2(`MIX_CLIP_HOLD_CYCLES + 1);
  localparam sample_t SAMPLE_POS = sample_t'(SAMPLE_MAX);
  localparam sample_t SAMPLE_NEG = sample_t'(SAMPLE_MIN);

  egress_state_t     state;
  sample_t           right_hold;
  logic              clip_any, clip_any_q;
  logic [HOLD_W-1:0] hold_cnt;

  ////////////////////
  // stream FSM
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= EGRESS_IDLE;
      dac_valid <= 1'b0;
      dac_last  <= 1'b0;
    end else begin
      case (state)
        EGRESS_IDLE: if (mix_valid) begin
          state     <= EGRESS_LEFT;
          dac_valid <= 1'b1;
          dac_last  <= 1'b0;
        end
        EGRESS_LEFT: if (dac_ready) begin
          state    <= EGRESS_RIGHT;
          dac_last <= 1'b1;            // right closes the frame
        end
        EGRESS_RIGHT: if (dac_ready) begin
          state     <= EGRESS_IDLE;
          dac_valid <= 1'b0;
          dac_last  <= 1'b0;
        end
        default: state <= EGRESS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == EGRESS_IDLE && mix_valid) begin
      dac_data   <= mix_out.left;
      right_hold <= mix_out.right;
    end else if (state == EGRESS_LEFT && dac_ready) begin
      dac_data <= right_hold;
    end
  end

  ////////////////////
  // amplitude and overrun
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dac_max <= SAMPLE_NEG;
      dac_min <= SAMPLE_POS;
      overrun <= 1'b0;
    end else if (clear) begin
      dac_max <= SAMPLE_NEG;
      dac_min <= SAMPLE_POS;
      overrun <= 1'b0;
    end else begin
      if (dac_valid && dac_ready) begin
        if (dac_data > dac_max) dac_max <= dac_data;
        if (dac_data < dac_min) dac_min <= dac_data;
      end
      if (mix_valid && state != EGRESS_IDLE)
        overrun <= 1'b1;                 // frame dropped
    end
  end

  // clip led, reload on each new clip
  assign clip_any = (|status.channel_clip) || (|status.out_clip);
  assign clip_led = (hold_cnt != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clip_any_q <= 1'b0;
      hold_cnt   <= '0;
    end else begin
      clip_any_q <= clip_any;
      if (clip_any && !clip_any_q)
        hold_cnt <= HOLD_W'(`MIX_CLIP_HOLD_CYCLES);
      else if (hold_cnt != '0)
        hold_cnt <= hold_cnt - 1'b1;
    end
  end

  data_stable_on_stall: assert property (
    @(posedge clk) disable iff (!rst_n) (dac_valid && !dac_ready) |=> $stable(dac_data)
  );

endmodule

// File: logic/mix_bus_sum.sv
`timescale 1ns/100ps
`include "mixer_defs.svh"

module mix_bus_sum import mixer_pkg::*; (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              ch_valid,
  input  sample_t [`MIX_NR_OF_CHANNELS-1:0] ch_left,
  input  sample_t [`MIX_NR_OF_CHANNELS-1:0] ch_right,
  input  coef_t                             output_gain,
  input  logic                              clear,
  output logic                              mix_valid,
  output stereo_t                           mix_out,
  output logic    [1:0]                     out_clip
);

  localparam int N = `MIX_NR_OF_CHANNELS;

  sample_t [1:0][N-1:0] side_in;    // index 0 left, 1 right
  sample_t [1:0]        sum_d, sum_q, out_d;
  logic    [1:0]        sum_clip_d, sum_clip_q, gain_clip_d;
  logic                 sum_valid;

  assign side_in[0] = ch_left;
  assign side_in[1] = ch_right;

  always_comb begin
    logic signed [63:0] acc;
    logic signed [63:0] scaled;
    for (int s = 0; s < 2; s++) begin
      acc = '0;
      for (int i = 0; i < N; i++)
        acc = acc + side_in[s][i];
      sum_d[s]       = sat_sample(acc);
      sum_clip_d[s]  = out_of_range(acc);
      // master gain on the registered sum
      scaled         = (sum_q[s] * $signed({1'b0, output_gain})) >>> `MIX_Q_BITS;
      out_d[s]       = sat_sample(scaled);
      gain_clip_d[s] = out_of_range(scaled);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_valid  <= 1'b0;
      mix_valid  <= 1'b0;
      sum_clip_q <= '0;
      out_clip   <= '0;
    end else begin
      sum_valid <= ch_valid;
      mix_valid <= sum_valid;
      if (ch_valid)
        sum_clip_q <= sum_clip_d;
      if (clear)
        out_clip <= '0;
      else if (sum_valid)
        out_clip <= out_clip | sum_clip_q | gain_clip_d;  // either clamp counts
    end
  end

  always_ff @(posedge clk) begin
    if (ch_valid)
      sum_q <= sum_d;
    if (sum_valid) begin
      mix_out.left  <= out_d[0];
      mix_out.right <= out_d[1];
    end
  end

endmodule

// File: logic/mix_channel_stage.sv
`timescale 1ns/100ps
`include "mixer_defs.svh"

module mix_channel_stage import mixer_pkg::*; (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            x_valid,
  input  sample_t [`MIX_NR_OF_CHANNELS-1:0] x_data,
  input  mix_cfg_t                        cfg,
  input  logic                            clear,
  output logic                            ch_valid,
  output sample_t [`MIX_NR_OF_CHANNELS-1:0] ch_left,
  output sample_t [`MIX_NR_OF_CHANNELS-1:0] ch_right,
  output logic    [`MIX_NR_OF_CHANNELS-1:0] channel_clip
);

  localparam int    N     = `MIX_NR_OF_CHANNELS;
  localparam coef_t UNITY = coef_t'(1 << `MIX_Q_BITS);

  sample_t [N-1:0] scaled_d, scaled_q;
  sample_t [N-1:0] left_d, right_d;
  logic    [N-1:0] clip_d;
  logic            scaled_valid;

  ////////////////////
  // gain, stage 1
  ////////////////////
  always_comb begin
    logic signed [63:0] prod;
    logic signed [63:0] shifted;
    for (int i = 0; i < N; i++) begin
      prod        = x_data[i] * $signed({1'b0, cfg.channel_gain[i]});
      shifted     = prod >>> `MIX_Q_BITS;           // floor
      scaled_d[i] = sat_sample(shifted);
      clip_d[i]   = out_of_range(shifted);
    end
  end

  ////////////////////
  // linear pan, stage 2
  ////////////////////
  always_comb begin
    coef_t              pan;
    logic signed [63:0] prod_l;
    logic signed [63:0] prod_r;
    for (int i = 0; i < N; i++) begin
      pan        = (cfg.channel_pan[i] > UNITY) ? UNITY : cfg.channel_pan[i];
      prod_l     = scaled_q[i] * $signed({1'b0, coef_t'(UNITY - pan)});
      prod_r     = scaled_q[i] * $signed({1'b0, pan});
      left_d[i]  = sample_t'(prod_l >>> `MIX_Q_BITS);  // |factor| <= 1, always fits
      right_d[i] = sample_t'(prod_r >>> `MIX_Q_BITS);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      scaled_valid <= 1'b0;
      ch_valid     <= 1'b0;
      channel_clip <= '0;
    end else begin
      scaled_valid <= x_valid;
      ch_valid     <= scaled_valid;
      if (clear)
        channel_clip <= '0;
      else if (x_valid)
        channel_clip <= channel_clip | clip_d;  // sticky
    end
  end

  always_ff @(posedge clk) begin
    if (x_valid)
      scaled_q <= scaled_d;
    if (scaled_valid) begin
      ch_left  <= left_d;
      ch_right <= right_d;
    end
  end

endmodule

// File: logic/mix_reg_decode.sv
`timescale 1ns/100ps
`include "mixer_defs.svh"

module mix_reg_decode import mixer_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         wb_cyc,
  input  logic         wb_stb,
  input  logic         wb_we,
  input  wb_addr_t     wb_adr,
  input  logic  [31:0] wb_dat_w,
  output logic  [31:0] wb_dat_r,
  output logic         wb_ack,
  input  clip_status_t status,
  input  logic         overrun,
  input  sample_t      dac_max,
  input  sample_t      dac_min,
  output mix_cfg_t     cfg,
  output logic         clear
);

  localparam int N = `MIX_NR_OF_CHANNELS;
  localparam int W = `MIX_AUDIO_WIDTH;

  logic        wb_req;
  logic [31:0] rd_data;

  assign wb_req = wb_cyc && wb_stb && !wb_ack;   // new cycle, not yet acked

  ////////////////////
  // handshake and writes
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
      clear  <= 1'b0;
      cfg    <= '0;
    end else begin
      wb_ack <= wb_req;
      clear  <= wb_req && wb_we && (wb_adr == wb_addr_t'(`MIX_REG_CMD)) && wb_dat_w[0];
      if (wb_req && wb_we) begin
        for (int i = 0; i < N; i++) begin
          if (wb_adr == wb_addr_t'(`MIX_REG_GAIN0 + i))
            cfg.channel_gain[i] <= wb_dat_w[W-1:0];
          if (wb_adr == wb_addr_t'(`MIX_REG_PAN0 + i))
            cfg.channel_pan[i] <= wb_dat_w[W-1:0];
        end
        if (wb_adr == wb_addr_t'(`MIX_REG_OUT_GAIN))
          cfg.output_gain <= wb_dat_w[W-1:0];
      end
    end
  end

  ////////////////////
  // read mux
  ////////////////////
  always_comb begin
    rd_data = '0;                                 // unmapped reads return zero
    for (int i = 0; i < N; i++) begin
      if (wb_adr == wb_addr_t'(`MIX_REG_GAIN0 + i))
        rd_data = {{(32-W){1'b0}}, cfg.channel_gain[i]};
      if (wb_adr == wb_addr_t'(`MIX_REG_PAN0 + i))
        rd_data = {{(32-W){1'b0}}, cfg.channel_pan[i]};
    end
    case (wb_adr)
      wb_addr_t'(`MIX_REG_OUT_GAIN): rd_data = {{(32-W){1'b0}}, cfg.output_gain};
      wb_addr_t'(`MIX_REG_STATUS):
        rd_data = {{(31-N-2){1'b0}}, overrun, status.out_clip, status.channel_clip};
      wb_addr_t'(`MIX_REG_MAX):    rd_data = {{(32-W){dac_max[W-1]}}, dac_max};
      wb_addr_t'(`MIX_REG_MIN):    rd_data = {{(32-W){dac_min[W-1]}}, dac_min};
      default: ;
    endcase
  end

  // data goes out together with ack
  always_ff @(posedge clk) begin
    if (wb_req)
      wb_dat_r <= rd_data;
  end

  ////////////////////
  // bus checks
  ////////////////////
  ack_one_cycle: assert property (
    @(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack
  );

  ack_after_strobe: assert property (
    @(posedge clk) disable iff (!rst_n) wb_ack |-> $past(wb_cyc && wb_stb)
  );

endmodule

// File: logic/mixer_pkg.sv
`include "mixer_defs.svh"

package mixer_pkg;

  typedef logic signed [`MIX_AUDIO_WIDTH-1:0] sample_t;
  typedef logic        [`MIX_AUDIO_WIDTH-1:0] coef_t;     // unsigned Q16
  typedef logic      [`MIX_WB_ADDR_WIDTH-1:0] wb_addr_t;

  typedef struct packed {
    sample_t left;
    sample_t right;
  } stereo_t;

  typedef struct packed {
    coef_t [`MIX_NR_OF_CHANNELS-1:0] channel_gain;
    coef_t [`MIX_NR_OF_CHANNELS-1:0] channel_pan;
    coef_t                           output_gain;
  } mix_cfg_t;

  typedef struct packed {
    logic [`MIX_NR_OF_CHANNELS-1:0] channel_clip;
    logic [1:0]                     out_clip;        // bit 0 left, bit 1 right
  } clip_status_t;

  typedef enum logic [1:0] {
    EGRESS_IDLE,
    EGRESS_LEFT,
    EGRESS_RIGHT
  } egress_state_t;

  localparam logic signed [63:0] SAMPLE_MAX = (64'sd1 <<< (`MIX_AUDIO_WIDTH-1)) - 64'sd1;
  localparam logic signed [63:0] SAMPLE_MIN = -(64'sd1 <<< (`MIX_AUDIO_WIDTH-1));

  function automatic logic out_of_range(input logic signed [63:0] v);
    return (v > SAMPLE_MAX) || (v < SAMPLE_MIN);
  endfunction

  // clamp a wide intermediate into the 24 bit range
  function automatic sample_t sat_sample(input logic signed [63:0] v);
    if (v > SAMPLE_MAX) return sample_t'(SAMPLE_MAX);
    if (v < SAMPLE_MIN) return sample_t'(SAMPLE_MIN);
    return sample_t'(v);
  endfunction

endpackage

// File: logic/mixer_top.sv
`timescale 1ns/100ps
`include "mixer_defs.svh"

module mixer_top import mixer_pkg::*; (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              x_valid,
  input  sample_t [`MIX_NR_OF_CHANNELS-1:0] x_data,
  output sample_t                           dac_data,
  output logic                              dac_valid,
  input  logic                              dac_ready,
  output logic                              dac_last,
  output logic                              clip_led,
  input  logic                              wb_cyc,
  input  logic                              wb_stb,
  input  logic                              wb_we,
  input  wb_addr_t                          wb_adr,
  input  logic    [31:0]                    wb_dat_w,
  output logic    [31:0]                    wb_dat_r,
  output logic                              wb_ack
);

  mix_cfg_t                          cfg;
  logic                              clear;
  logic                              ch_valid;
  sample_t [`MIX_NR_OF_CHANNELS-1:0] ch_left, ch_right;
  logic    [`MIX_NR_OF_CHANNELS-1:0] channel_clip;
  logic                              mix_valid;
  stereo_t                           mix_out;
  logic    [1:0]                     out_clip;
  clip_status_t                      status;
  sample_t                           dac_max, dac_min;
  logic                              overrun;

  // status is just the sticky flags side by side
  assign status.channel_clip = channel_clip;
  assign status.out_clip     = out_clip;

  mix_reg_decode reg_decode0 (
    .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
    .status, .overrun, .dac_max, .dac_min, .cfg, .clear
  );

  mix_channel_stage channel_stage0 (
    .clk, .rst_n, .x_valid, .x_data, .cfg, .clear,
    .ch_valid, .ch_left, .ch_right, .channel_clip
  );

  mix_bus_sum bus_sum0 (
    .clk, .rst_n, .ch_valid, .ch_left, .ch_right,
    .output_gain (cfg.output_gain),
    .clear, .mix_valid, .mix_out, .out_clip
  );

  dac_egress egress0 (
    .clk, .rst_n, .mix_valid, .mix_out, .dac_ready, .clear, .status,
    .dac_data, .dac_valid, .dac_last, .dac_max, .dac_min, .overrun, .clip_led
  );

endmodule

// File: mixer.f
+incdir+include
logic/mixer_pkg.sv
logic/mix_reg_decode.sv
logic/mix_channel_stage.sv
logic/mix_bus_sum.sv
logic/dac_egress.sv
logic/mixer_top.sv
testbench/tb_mixer.sv

// File: testbench/tb_mixer.sv
`timescale 1ns/100ps
`include "mixer_defs.svh"

module tb_mixer import mixer_pkg::*; ();

  localparam int N = `MIX_NR_OF_CHANNELS;

  logic            clk;
  logic            rst_n;
  logic            x_valid;
  sample_t [N-1:0] x_data;
  logic            dac_ready;
  sample_t         dac_data;
  logic            dac_valid, dac_last, clip_led;
  logic            wb_cyc, wb_stb, wb_we;
  wb_addr_t        wb_adr;
  logic [31:0]     wb_dat_w, wb_dat_r;
  logic            wb_ack;

  integer seed = 19284;
  int     errors = 0;
  int     ack_count = 0;
  int     ready_mode = 2;        // 0 low, 1 random, 2 high

  // model state
  coef_t         mgain[N], mpan[N], mog;
  logic [N-1:0]  mclip_ch;
  logic [1:0]    mclip_out;
  logic          movr;
  sample_t       mmax, mmin;
  egress_state_t mstate;
  logic          dly_v[4];
  sample_t       dly_l[4], dly_r[4];
  sample_t       exp_data_q[$];
  logic          exp_last_q[$];
  logic          exp_pending, exp_last;
  sample_t       exp_data;

  mixer_top dut0 (
    .clk, .rst_n, .x_valid, .x_data, .dac_data, .dac_valid, .dac_ready, .dac_last,
    .clip_led, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
  );

  always #5 clk = ~clk;

  //////////////////////
  // reference model
  //////////////////////
  function automatic longint clamp(input longint v);
    if (v > 64'sd8388607) return 64'sd8388607;
    if (v < -64'sd8388608) return -64'sd8388608;
    return v;
  endfunction

  function automatic void mix_frame(input sample_t [N-1:0] x, output sample_t l,
                                    output sample_t r, output logic [N-1:0] cc,
                                    output logic [1:0] oc);
    longint raw, s, p, acc_l, acc_r, v;
    acc_l = 0;
    acc_r = 0;
    for (int i = 0; i < N; i++) begin
      raw   = (longint'(x[i]) * longint'(mgain[i])) >>> 16;
      cc[i] = (raw != clamp(raw));
      s     = clamp(raw);
      p     = (mpan[i] > 65536) ? 65536 : longint'(mpan[i]);   // pan law limit
      acc_l = acc_l + ((s * (65536 - p)) >>> 16);
      acc_r = acc_r + ((s * p) >>> 16);
    end
    oc[0] = (acc_l != clamp(acc_l));
    v     = (clamp(acc_l) * longint'(mog)) >>> 16;
    oc[0] = oc[0] | (v != clamp(v));
    l     = sample_t'(clamp(v));
    oc[1] = (acc_r != clamp(acc_r));
    v     = (clamp(acc_r) * longint'(mog)) >>> 16;
    oc[1] = oc[1] | (v != clamp(v));
    r     = sample_t'(clamp(v));
  endfunction

  always @(posedge clk) begin : model
    sample_t      l, r;
    logic [N-1:0] cc;
    logic [1:0]   oc;
    logic         arrive;
    sample_t      al, ar;
    if (!rst_n) begin
      mstate = EGRESS_IDLE;
      for (int k = 0; k < 4; k++) dly_v[k] = 1'b0;
      exp_data_q.delete();
      exp_last_q.delete();
    end else begin
      // sample taken by the DAC
      if (mstate != EGRESS_IDLE && dac_ready && exp_data_q.size() > 0) begin
        if (exp_data_q[0] > mmax) mmax = exp_data_q[0];
        if (exp_data_q[0] < mmin) mmin = exp_data_q[0];
        void'(exp_data_q.pop_front());
        void'(exp_last_q.pop_front());
      end
      arrive = dly_v[3];
      al     = dly_l[3];
      ar     = dly_r[3];
      for (int k = 3; k > 0; k--) begin
        dly_v[k] = dly_v[k-1];
        dly_l[k] = dly_l[k-1];
        dly_r[k] = dly_r[k-1];
      end
      dly_v[0] = x_valid;
      if (x_valid) begin
        mix_frame(x_data, l, r, cc, oc);
        dly_l[0]  = l;
        dly_r[0]  = r;
        mclip_ch  = mclip_ch | cc;
        mclip_out = mclip_out | oc;
      end
      if (arrive && mstate != EGRESS_IDLE)
        movr = 1'b1;                     // busy egress drops the frame
      case (mstate)
        EGRESS_IDLE:  if (arrive) begin
          mstate = EGRESS_LEFT;
          exp_data_q.push_back(al);
          exp_last_q.push_back(1'b0);
          exp_data_q.push_back(ar);
          exp_last_q.push_back(1'b1);
        end
        EGRESS_LEFT:  if (dac_ready) mstate = EGRESS_RIGHT;
        default:      if (dac_ready) mstate = EGRESS_IDLE;
      endcase
    end
    exp_pending = (exp_data_q.size() > 0);
    exp_data    = exp_pending ? exp_data_q[0] : '0;
    exp_last    = exp_pending ? exp_last_q[0] : 1'b0;
  end

  //////////////////////
  // checks
  //////////////////////
  stream_matches: assert property (@(posedge clk) disable iff (!rst_n)
    (dac_valid && dac_ready) |-> (exp_pending && dac_data == exp_data && dac_last == exp_last))
    else begin
      errors++;
      $display("CHECK FAILED at %0t: dac sample %0d last %b, expected %0d last %b",
               $time, dac_data, dac_last, exp_data, exp_last);
    end

  valid_matches: assert property (@(posedge clk) disable iff (!rst_n)
    dac_valid == (mstate != EGRESS_IDLE))
    else begin
      errors++;
      $display("CHECK FAILED at %0t: dac_valid is %b against the egress model", $time, dac_valid);
    end

  ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |-> (wb_cyc && wb_stb))
    else begin
      errors++;
      $display("CHECK FAILED at %0t: wb_ack outside a bus cycle", $time);
    end

  always @(posedge clk) begin
    int r;
    r = $random(seed);
    if (wb_ack) ack_count <= ack_count + 1;
    dac_ready <= (ready_mode == 2) || (ready_mode == 1 && r[0]);
  end

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic wb_access(input logic we, input int adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int n0;
    int waited;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= wb_addr_t'(adr);
    wb_dat_w <= wdat;
    n0       = ack_count;
    waited   = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!wb_ack && waited < 20);
    if (!wb_ack) begin
      errors++;
      $display("Wishbone access to address %0d was never acknowledged", adr);
    end
    rdat = wb_dat_r;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    repeat (2) @(posedge clk);
    check_value("ack count of one access", ack_count - n0, 1);
  endtask

  task automatic wb_write(input int adr, input logic [31:0] dat);
    logic [31:0] unused;
    wb_access(1'b1, adr, dat, unused);
    if (adr >= `MIX_REG_GAIN0 && adr < `MIX_REG_GAIN0 + N) mgain[adr - `MIX_REG_GAIN0] = dat[23:0];
    if (adr >= `MIX_REG_PAN0 && adr < `MIX_REG_PAN0 + N) mpan[adr - `MIX_REG_PAN0] = dat[23:0];
    if (adr == `MIX_REG_OUT_GAIN) mog = dat[23:0];
    if (adr == `MIX_REG_CMD && dat[0]) begin
      mclip_ch  = '0;
      mclip_out = '0;
      movr      = 1'b0;
      mmax      = -24'sd8388608;
      mmin      = 24'sd8388607;
    end
  endtask

  task automatic wb_read_check(input int adr, input logic [31:0] exp);
    logic [31:0] rd;
    wb_access(1'b0, adr, '0, rd);
    check_value($sformatf("register %0d", adr), rd, exp);
  endtask

  task automatic send_frame(input sample_t [N-1:0] d, input int gap);
    @(posedge clk);
    x_valid <= 1'b1;
    x_data  <= d;
    @(posedge clk);
    x_valid <= 1'b0;
    repeat (gap - 2) @(posedge clk);
  endtask

  task automatic drain;
    int waited;
    waited = 0;
    while ((exp_pending || mstate != EGRESS_IDLE || dly_v[0] || dly_v[1] || dly_v[2]
            || dly_v[3]) && waited < 300) begin
      @(posedge clk);
      waited++;
    end
    if (waited >= 300) begin
      errors++;
      $display("DAC stream did not drain at %0t", $time);
    end
  endtask

  function automatic logic [31:0] status_word();
    return {25'd0, movr, mclip_out, mclip_ch};
  endfunction

  initial begin
    #((400 * 12 * 10) + 20000);
    $display("Timeout: the run did not finish within the expected time");
    $display("Checks failed");
    $finish;
  end

  initial begin
    sample_t [N-1:0] d;
    int              r;
    int              waited;
    clk = 1'b0;
    rst_n = 1'b0;
    x_valid = 1'b0;
    x_data = '0;
    dac_ready = 1'b0;
    {wb_cyc, wb_stb, wb_we} = '0;
    wb_adr = '0;
    wb_dat_w = '0;
    for (int i = 0; i < N; i++) begin
      mgain[i] = '0;
      mpan[i]  = '0;
    end
    mog = '0;
    {mclip_ch, mclip_out, movr} = '0;
    mmax = -24'sd8388608;
    mmin = 24'sd8388607;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // reset values and unused addresses
    check_value("dac_valid after reset", dac_valid, 0);
    check_value("clip_led after reset", clip_led, 0);
    for (int a = 0; a < 16; a++) begin
      if (a == `MIX_REG_MAX) wb_read_check(a, 32'hFF80_0000);
      else if (a == `MIX_REG_MIN) wb_read_check(a, 32'h007F_FFFF);
      else wb_read_check(a, 32'h0);
    end

    // random gains, pans and samples
    ready_mode = 1;
    for (int blk = 0; blk < 10; blk++) begin
      for (int i = 0; i < N; i++) begin
        r = $random(seed);
        wb_write(`MIX_REG_GAIN0 + i, r & 32'h1_FFFF);
        r = $random(seed);
        wb_write(`MIX_REG_PAN0 + i, r & 32'h1_3FFF);   // sometimes above unity
      end
      r = $random(seed);
      wb_write(`MIX_REG_OUT_GAIN, r & 32'h1_FFFF);
      for (int f = 0; f < 20; f++) begin
        for (int i = 0; i < N; i++) begin
          r = $random(seed);
          d[i] = r[23:0];
        end
        send_frame(d, 12);
      end
      drain();
    end

    // extremes, then clear
    wb_read_check(`MIX_REG_MAX, {{8{mmax[23]}}, mmax});
    wb_read_check(`MIX_REG_MIN, {{8{mmin[23]}}, mmin});
    wb_read_check(`MIX_REG_STATUS, status_word());
    wb_write(`MIX_REG_CMD, 32'h1);
    wb_read_check(`MIX_REG_MAX, 32'hFF80_0000);
    wb_read_check(`MIX_REG_MIN, 32'h007F_FFFF);
    wb_read_check(`MIX_REG_STATUS, 32'h0);

    // full scale with gain 4.0
    for (int i = 0; i < N; i++) begin
      wb_write(`MIX_REG_GAIN0 + i, 32'h4_0000);
      wb_write(`MIX_REG_PAN0 + i, 32'h8000);
    end
    wb_write(`MIX_REG_OUT_GAIN, 32'h1_0000);
    ready_mode = 2;
    d = {N{24'sh7F_FFFF}};
    send_frame(d, 2);
    waited = 0;
    while (!dac_valid && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    waited = 0;
    while (!clip_led && waited < 5) begin
      @(posedge clk);
      waited++;
    end
    check_value("clip_led after clip", clip_led, 1);
    d = {N{24'sh80_0000}};
    send_frame(d, 12);
    drain();
    check_value("model status clip bits", status_word(), 32'h3F);
    wb_read_check(`MIX_REG_STATUS, status_word());
    wb_read_check(`MIX_REG_MAX, 32'h007F_FFFF);
    wb_read_check(`MIX_REG_MIN, 32'hFF80_0000);

    // back-to-back strobes into a stalled DAC
    wb_write(`MIX_REG_CMD, 32'h1);
    ready_mode = 0;
    for (int f = 0; f < 6; f++) begin
      for (int i = 0; i < N; i++) begin
        r = $random(seed);
        d[i] = r[23:0];
      end
      send_frame(d, 2);
    end
    repeat (8) @(posedge clk);
    ready_mode = 1;
    drain();
    check_value("model overrun", movr, 1);
    wb_read_check(`MIX_REG_STATUS, status_word());

    $display("error count: %0d", errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule
